/* all.f */
+incdir+src
src/neuronTypesPkg.sv
src/neuronWeightsPkg.sv
src/weightMultiply.sv
src/accumulate.sv
src/reluQuantize.sv
src/neuronTop.sv
tb/clockGen.sv
tb/neuronTb.sv

/* Makefile */
# Verilator flow for the neuron pipeline
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP ?= neuronTb
FILELIST ?= all.f
OBJDIR ?= obj_dir
LOG ?= sim.log
LINT_FLAGS ?= --lint-only --timing
BUILD_FLAGS ?= --binary --timing
PASS_TEXT ?= Everything OK

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY := $(OBJDIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BINARY): $(SOURCES) $(FILELIST) src/neuron_settings.svh
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

build: $(BINARY)

# the log decides pass or fail, not the exit code of the binary
sim: $(BINARY)
	./$(BINARY) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tb/neuronTb.sv */
`default_nettype none
`timescale 1ns/100ps

`include "neuron_settings.svh"

module neuronTb;

	localparam int resetCycles = 5;
	localparam int rowCount = 15;
	localparam int randomVectors = 64;
	localparam int latency = 3;
	// reset phase, table, random stream, latency and the mid-run reset
	localparam int timeoutCycles =
		2 * (resetCycles + rowCount + randomVectors + latency + 3);
	localparam logic [31:0] lfsrSeed = 32'h3545f3d7;
	localparam logic [31:0] lfsrTaps = 32'h80200003;

	// one table row, up to two active lanes
	// a pair with value zero is skipped
	typedef struct packed {
		logic [$clog2(`NEURON_INPUTS)-1:0] idxA;
		neuronTypesPkg::dataWord valA;
		logic [$clog2(`NEURON_INPUTS)-1:0] idxB;
		neuronTypesPkg::dataWord valB;
		neuronTypesPkg::neuronOut expected;
	} rowValues;

	// expected outputs worked out by hand from weights and bias
	localparam rowValues stimTable [0:rowCount-1] = '{
		'{4'd0, 32'sd0, 4'd0, 32'sd0, 16'd0}, // bias alone is negative
		'{4'd4, 32'sd8192, 4'd0, 32'sd0, 16'd4587},
		'{4'd4, 32'sd24576, 4'd0, 32'sd0, 16'd13763},
		'{4'd3, 32'sd8192, 4'd0, 32'sd0, 16'd2854},
		'{4'd3, 32'sd40960, 4'd0, 32'sd0, 16'd14274},
		'{4'd0, 32'sd16384, 4'd0, 32'sd0, 16'd1031},
		'{4'd2, 32'sd8192, 4'd0, 32'sd0, 16'd0}, // negative weight clamps
		'{4'd2, 32'sd100000, 4'd0, 32'sd0, 16'd0},
		'{4'd1, -32'sd8192, 4'd0, 32'sd0, 16'd528}, // two negatives
		'{4'd3, 32'sd8192, 4'd4, 32'sd8192, 16'd7442},
		'{4'd0, 32'sd1, 4'd4, 32'sd8192, 16'd4588}, // lifts fraction above the bias
		'{4'd4, 32'sd163840, 4'd0, 32'sd0, 16'd26223}, // bits 30:29 = 1
		'{4'd4, 32'sd409600, 4'd0, 32'sd0, 16'd32791}, // bits 30:29 = 3
		'{4'd4, 32'sd491520, 4'd0, 32'sd0, 16'd0}, // wraps past 2^31
		'{4'd15, 32'sd16384, 4'd0, 32'sd0, 16'd1821}
	};

	string rowNames [0:rowCount-1] = '{
		"allZero", "in4x1", "in4x3", "in3x1", "in3x5",
		"in0x2", "in2pos", "in2big", "in1neg", "in3in4",
		"fracCarry", "slice4x20", "slice4x50", "wrapNeg", "in15x2"
	};

	logic clk;
	logic reset;
	logic resetRequest;
	neuronTypesPkg::activationVec activations;
	neuronTypesPkg::neuronOut activation;

	logic [31:0] lfsrState;
	int cycleCount = 0;

	// expected outputs still in flight, oldest first
	string nameQ [$];
	neuronTypesPkg::neuronOut expQ [$];

	clockGen #(.startupCycles(resetCycles)) clocking0
	(
		.resetRequest(resetRequest),
		.clk(clk),
		.reset(reset)
	);

	neuronTop DUT
	(
		.clk(clk),
		.reset(reset),
		.activations(activations),
		.activation(activation)
	);

	task automatic checkValue(input string testName, input neuronTypesPkg::neuronOut expected,
		input neuronTypesPkg::neuronOut actual);
		if (expected !== actual)
		begin
			$display("MISMATCH test %s expected %0d actual %0d", testName, expected, actual);
			$display("Something failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	// one Galois step, shifting right
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ lfsrTaps;
		else
			return state >> 1;
	endfunction

	function automatic logic [31:0] takeBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			bits = {bits[30:0], lfsrState[0]}; // one step per bit
		end
		return bits;
	endfunction

	// mostly 16-bit signed lanes, every fourth vector uses full 32-bit lanes
	function automatic neuronTypesPkg::activationVec randomVector(input int n);
		neuronTypesPkg::activationVec vec;
		logic [31:0] bits;
		for (int i = 0; i < `NEURON_INPUTS; i++)
		begin
			if (n % 4 == 3)
				vec.act[i] = takeBits(32);
			else
			begin
				bits = takeBits(16);
				vec.act[i] = {{16{bits[15]}}, bits[15:0]};
			end
		end
		return vec;
	endfunction

	function automatic neuronTypesPkg::activationVec rowVector(input rowValues row);
		neuronTypesPkg::activationVec vec;
		vec = '0;
		if (row.valA != 0)
			vec.act[row.idxA] = row.valA;
		if (row.valB != 0)
			vec.act[row.idxB] = row.valB;
		return vec;
	endfunction

	// straight chain of wrapping adds, then sign test and bits 28:13
	function automatic neuronTypesPkg::neuronOut refOutput(
		input neuronTypesPkg::activationVec vec);
		neuronTypesPkg::dataWord acc;
		acc = neuronWeightsPkg::bias;
		for (int i = 0; i < `NEURON_INPUTS; i++)
			acc = acc + vec.act[i] * neuronWeightsPkg::weights[i];
		if (acc < 0)
			return '0;
		else
			return acc[`NEURON_FRAC_SHIFT+`NEURON_OUT_WIDTH-1:`NEURON_FRAC_SHIFT];
	endfunction

	// drive one vector, then check the output that is due on this clock
	task automatic driveCycle(input string testName, input neuronTypesPkg::activationVec vec,
		input neuronTypesPkg::neuronOut expected, input logic doReset);
		string dueName;
		neuronTypesPkg::neuronOut dueValue;
		@(posedge clk);
		activations <= vec;
		resetRequest <= doReset;
		nameQ.push_back(testName);
		if (doReset)
		begin
			expQ.push_back('0);
			// everything still in the pipeline gets flushed
			for (int i = expQ.size() - latency; i < expQ.size(); i++)
				if (i >= 0)
					expQ[i] = '0;
		end
		else
			expQ.push_back(expected);
		@(negedge clk);
		if (expQ.size() > latency)
		begin
			dueName = nameQ.pop_front();
			dueValue = expQ.pop_front();
			checkValue(dueName, dueValue, activation);
		end
	endtask

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles)
		begin
			$display("timeout: run did not finish within %0d cycles", timeoutCycles);
			$display("Something failed");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		neuronTypesPkg::activationVec vec;
		activations = '0;
		resetRequest = 1'b0;
		lfsrState = lfsrSeed;

		// outputs during the first edges of reset
		repeat (latency)
		begin
			nameQ.push_back("reset");
			expQ.push_back('0);
		end
		repeat (resetCycles) driveCycle("reset", '0, '0, 1'b0);

		for (int r = 0; r < rowCount; r++)
		begin
			vec = rowVector(stimTable[r]);
			checkValue({rowNames[r], " reference"}, stimTable[r].expected, refOutput(vec));
			driveCycle(rowNames[r], vec, stimTable[r].expected, 1'b0);
		end

		for (int n = 0; n < randomVectors; n++)
		begin
			if (n == randomVectors / 2)
				driveCycle("midReset", randomVector(n), '0, 1'b1); // one clock of reset
			vec = randomVector(n);
			driveCycle($sformatf("random%0d", n), vec, refOutput(vec), 1'b0);
		end

		repeat (latency) driveCycle("drain", '0, '0, 1'b0); // flush the last results

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/clockGen.sv */
`default_nettype none
`timescale 1ns/100ps

// free running clock plus a power-on reset of a fixed number of cycles
// resetRequest lets the testbench pulse reset again later on
module clockGen
#(
	parameter int halfPeriod = 50,
	parameter int startupCycles = 5
)
(
	input logic resetRequest,
	output logic clk,
	output logic reset
);

	logic startup;

	initial
	begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk; // 100 ns period
	end

	initial
	begin
		startup = 1'b1;
		repeat (startupCycles) @(posedge clk);
		startup <= 1'b0; // released on an edge like every other input
	end

	assign reset = startup | resetRequest;

endmodule

`default_nettype wire

/* src/neuronTop.sv */
`default_nettype none
`timescale 1ns/100ps

// three stage pipeline
// multiply, then accumulate, then relu and quantize
// output follows the input vector by exactly three clocks
module neuronTop
(
	input logic clk,
	input logic reset,
	input neuronTypesPkg::activationVec activations,
	output neuronTypesPkg::neuronOut activation
);

	neuronTypesPkg::productVec products; // stage 1 register
	neuronTypesPkg::sumWord sum; // stage 2 register

	weightMultiply multiplyStage
	(
		.clk(clk),
		.reset(reset),
		.activations(activations),
		.products(products)
	);

	accumulate accumulateStage
	(
		.clk(clk),
		.reset(reset),
		.products(products),
		.sum(sum)
	);

	// stage 3 register lives inside
	reluQuantize reluStage
	(
		.clk(clk),
		.reset(reset),
		.sum(sum),
		.activation(activation)
	);

endmodule

`default_nettype wire

/* src/reluQuantize.sv */
`default_nettype none
`timescale 1ns/100ps

`include "neuron_settings.svh"

module reluQuantize
(
	input logic clk,
	input logic reset,
	input neuronTypesPkg::sumWord sum,
	output neuronTypesPkg::neuronOut activation
);

	neuronTypesPkg::neuronOut relu;

	// negative sums clamp to zero
	// otherwise take the scaled field, i.e. the sum shifted right by 13
	// and cut to the output width
	always_comb
	begin
		if (sum.fields.sign)
			relu = {`NEURON_OUT_WIDTH{1'b0}};
		else
			relu = sum.fields.scaled;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			activation <= {`NEURON_OUT_WIDTH{1'b0}};
		else
			activation <= relu;
	end

endmodule

`default_nettype wire

/* src/accumulate.sv */
`default_nettype none
`timescale 1ns/100ps

`include "neuron_settings.svh"

module accumulate
(
	input logic clk,
	input logic reset,
	input neuronTypesPkg::productVec products,
	output neuronTypesPkg::sumWord sum
);

	// working terms of the adder tree
	neuronTypesPkg::dataWord partial [0:`NEURON_INPUTS-1];
	neuronTypesPkg::dataWord total; // tree result plus bias

	// balanced tree, each level adds neighbouring pairs
	// and the surviving terms move down to the low indices
	always_comb
	begin
		for (int i = 0; i < `NEURON_INPUTS; i++)
			partial[i] = products.prod[i];

		for (int span = `NEURON_INPUTS / 2; span > 0; span = span / 2)
		begin
			for (int i = 0; i < span; i++)
				partial[i] = partial[2 * i] + partial[2 * i + 1];
		end

		// bias goes in last, the sum wraps just like a plain chain
		total = partial[0] + neuronWeightsPkg::bias;
	end

	// written as a number, read downstream as fields
	always_ff @(posedge clk)
	begin
		if (reset)
			sum.value <= '0;
		else
			sum.value <= total;
	end

endmodule

`default_nettype wire

/* src/weightMultiply.sv */
`default_nettype none
`timescale 1ns/100ps

`include "neuron_settings.svh"

module weightMultiply
(
	input logic clk,
	input logic reset,
	input neuronTypesPkg::activationVec activations,
	output neuronTypesPkg::productVec products
);

	// unregistered products of all lanes
	wire neuronTypesPkg::productVec weighted;

	genvar lane;

	// one constant-coefficient multiplier per lane
	generate
		for (lane = 0; lane < `NEURON_INPUTS; lane++)
		begin : gLane
			// keep the low bits only, overflow wraps
			assign weighted.prod[lane] =
				activations.act[lane] * neuronWeightsPkg::weights[lane];
		end
	endgenerate

	// products are registered here instead of the raw inputs
	always_ff @(posedge clk)
	begin
		if (reset)
			products <= '0;
		else
			products <= weighted; // new vector every clock
	end

endmodule

`default_nettype wire

/* src/neuronWeightsPkg.sv */
`default_nettype none

`include "neuron_settings.svh"

package neuronWeightsPkg;

	// trained weights of the neuron
	// entry i scales activation i
	localparam neuronTypesPkg::dataWord weights [0:`NEURON_INPUTS-1] = '{
		516,
		-529,
		-1732, // only strongly negative weight in the first group
		2855,
		4588, // largest weight
		2679,
		-2229,
		-702,
		-531,
		-354,
		-1935,
		-40,
		-813,
		476,
		931,
		911
	};

	// trained bias added once to the weighted sum
	// negative so an all-zero vector gives a clamped output
	localparam neuronTypesPkg::dataWord bias = -243;

endpackage

`default_nettype wire

/* src/neuronTypesPkg.sv */
`default_nettype none

`include "neuron_settings.svh"

package neuronTypesPkg;

	// one signed fixed-point word
	typedef logic signed [`NEURON_DATA_WIDTH-1:0] dataWord;

	// input vector of the neuron
	// element 0 sits in the top bits of the packed word
	typedef struct packed {
		dataWord [0:`NEURON_INPUTS-1] act;
	} activationVec;

	// weighted activations, same lane order as activationVec
	typedef struct packed {
		dataWord [0:`NEURON_INPUTS-1] prod;
	} productVec;

	// fixed-point layout of the accumulated sum, msb first
	typedef struct packed {
		logic sign; // bit 31
		// bits above the output field, lost by the quantizer
		logic [`NEURON_DATA_WIDTH-`NEURON_OUT_WIDTH-`NEURON_FRAC_SHIFT-2:0] dropped;
		logic [`NEURON_OUT_WIDTH-1:0] scaled; // bits 28 down to 13
		logic [`NEURON_FRAC_SHIFT-1:0] fraction;
	} sumFields;

	// the sum is produced as a number and consumed as bit fields
	typedef union packed {
		dataWord value;
		sumFields fields;
	} sumWord;

	// quantized output of the neuron
	typedef logic [`NEURON_OUT_WIDTH-1:0] neuronOut;

endpackage

`default_nettype wire

/* src/neuron_settings.svh */
`ifndef NEURON_SETTINGS_SVH
`define NEURON_SETTINGS_SVH

// number of activations in one input vector
// the adder tree in accumulate halves this count per level
// so it stays a power of two
`define NEURON_INPUTS 16

// activations, weights, products and the sum all share this width
// all arithmetic wraps at this many bits in two's complement
`define NEURON_DATA_WIDTH 32

`define NEURON_OUT_WIDTH 16 // width of the quantized relu result

// fraction bits below the output field
// the output takes the sum bits from here upward
`define NEURON_FRAC_SHIFT 13

`endif
